// File: source/axi_wr_defs.svh
// ------------------------------------------------
// Widths and limits for the AXI write slave
// OST_DEPTH must stay a power of 2
// awlen above MAX_BURST_LEN-1 is outside the contract
// ------------------------------------------------
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// AXI field widths
`define AXI_ID_W        4
`define AXI_USER_W      4
`define AXI_LEN_W       8

// Table and burst limits
`define OST_DEPTH       4
`define MAX_BURST_LEN   8

// Backend model, response ready 31 minus ID cycles after last beat
`define RESP_DLY_MAX    31
`define ERR_ID          15

`endif

// File: source/axi_wr_pkg.sv
// ------------------------------------------------
// Types shared by the write slave blocks
// Slot index width follows OST_DEPTH
// ------------------------------------------------
`include "axi_wr_defs.svh"

package axi_wr_pkg;

    // Index of one outstanding table entry
    typedef logic [$clog2(`OST_DEPTH)-1:0] slot_t;

    // AXI transaction ID and user tag
    typedef logic [`AXI_ID_W-1:0]   id_t;
    typedef logic [`AXI_USER_W-1:0] user_t;

    // Life cycle of one table entry
    typedef enum logic [1:0] {
        EMPTY        = 2'd0,
        AWAIT_DATA   = 2'd1,
        WAIT_BACKEND = 2'd2,
        RESP_READY   = 2'd3
    } entry_state_e;

    // B channel codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } bresp_e;

endpackage

// File: source/wr_slot_if.sv
// ------------------------------------------------
// Links between intake, table and scheduler
// Modport tbl is the table side of both links
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

// Intake to table: slot allocation and end of data
interface alloc_if;
    import axi_wr_pkg::*;

    logic                  alloc;
    slot_t                 alloc_slot;
    id_t                   alloc_id;
    user_t                 alloc_user;
    logic                  data_done;
    slot_t                 done_slot;
    logic [`OST_DEPTH-1:0] free_mask;

    modport intake (
        output alloc, alloc_slot, alloc_id, alloc_user, data_done, done_slot,
        input  free_mask
    );

    modport tbl (
        input  alloc, alloc_slot, alloc_id, alloc_user, data_done, done_slot,
        output free_mask
    );
endinterface

// Table to scheduler: ready entries and the selected one
interface resp_if;
    import axi_wr_pkg::*;

    logic [`OST_DEPTH-1:0] ready_mask;
    slot_t                 sel_slot;
    id_t                   sel_id;
    user_t                 sel_user;
    bresp_e                sel_resp;
    logic                  retire;

    modport tbl (
        output ready_mask, sel_id, sel_user, sel_resp,
        input  sel_slot, retire
    );

    modport sched (
        input  ready_mask, sel_id, sel_user, sel_resp,
        output sel_slot, retire
    );
endinterface

// File: source/wr_intake.sv
// ------------------------------------------------
// AW intake and W beat steering
// W beats belong to the oldest write awaiting data
// wlast ends a write even if the count disagrees
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module wr_intake (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  axi_wr_pkg::id_t       awid,
    input  axi_wr_pkg::user_t     awuser,
    input  logic [`AXI_LEN_W-1:0] awlen,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic                  wlast,
    alloc_if.intake               alloc
);
    import axi_wr_pkg::*;

    localparam int BEAT_W = $clog2(`MAX_BURST_LEN);
    localparam int CNT_W  = $clog2(`OST_DEPTH) + 1;

    // Writes awaiting data, oldest at rd_ptr
    slot_t             q_slot [`OST_DEPTH];
    logic [BEAT_W-1:0] q_len  [`OST_DEPTH];
    slot_t             wr_ptr;
    slot_t             rd_ptr;
    logic [CNT_W-1:0]  q_cnt;

    logic [BEAT_W-1:0] beat_cnt;
    logic              len_hit;
    logic              aw_hs;
    logic              w_hs;
    slot_t             free_slot;
    logic              free_any;

    // ------------------------------------------------
    // Lowest free slot
    // ------------------------------------------------
    always_comb begin
        free_slot = '0;
        free_any  = 1'b0;
        for (int i = `OST_DEPTH - 1; i >= 0; i--) begin
            if (alloc.free_mask[i]) begin
                free_slot = slot_t'(i);
                free_any  = 1'b1;
            end
        end
    end

    assign awready = free_any;
    assign aw_hs   = awvalid & awready;
    assign wready  = (q_cnt != '0);
    assign w_hs    = wvalid & wready;

    assign alloc.alloc      = aw_hs;
    assign alloc.alloc_slot = free_slot;
    assign alloc.alloc_id   = awid;
    assign alloc.alloc_user = awuser;
    assign alloc.data_done  = w_hs & wlast;
    assign alloc.done_slot  = q_slot[rd_ptr];

    // ------------------------------------------------
    // In-order queue of writes awaiting data
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            q_slot[wr_ptr] <= free_slot;
            q_len[wr_ptr]  <= awlen[BEAT_W-1:0];
        end
    end

    // Never overflows, one entry per occupied slot at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (aw_hs) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (alloc.data_done) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({aw_hs, alloc.data_done})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // Beat count of the head write, holds at awlen on an overlong burst
    assign len_hit = (beat_cnt == q_len[rd_ptr]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (alloc.data_done) begin
            beat_cnt <= '0;
        end else if (w_hs && !len_hit) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

// File: source/ost_table.sv
// ------------------------------------------------
// Table of outstanding writes
// Same-ID order count is fixed at allocation
// An entry frees on its B handshake
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module ost_table (
    input  logic   clk,
    input  logic   rst_n,
    alloc_if.tbl   alloc,
    resp_if.tbl    resp
);
    import axi_wr_pkg::*;

    localparam int DLY_W = $clog2(`RESP_DLY_MAX + 1);

    entry_state_e     ent_state [`OST_DEPTH];
    id_t              ent_id    [`OST_DEPTH];
    user_t            ent_user  [`OST_DEPTH];
    bresp_e           ent_resp  [`OST_DEPTH];
    logic [DLY_W-1:0] ent_dly   [`OST_DEPTH];
    // Older outstanding writes with the same ID
    slot_t            ent_ord   [`OST_DEPTH];

    logic [`OST_DEPTH-1:0] alloc_hit;
    logic [`OST_DEPTH-1:0] done_hit;
    logic [`OST_DEPTH-1:0] retire_hit;
    logic [`OST_DEPTH-1:0] dly_hit;
    slot_t                 alloc_ord;

    // ------------------------------------------------
    // Per-entry events and status masks
    // ------------------------------------------------
    always_comb begin
        for (int i = 0; i < `OST_DEPTH; i++) begin
            alloc_hit[i]  = alloc.alloc && (alloc.alloc_slot == slot_t'(i));
            done_hit[i]   = alloc.data_done && (alloc.done_slot == slot_t'(i));
            retire_hit[i] = resp.retire && (resp.sel_slot == slot_t'(i));
            // Backend done once the counter reaches 31 minus ID
            dly_hit[i]    = (ent_dly[i] == DLY_W'(`RESP_DLY_MAX) - DLY_W'(ent_id[i]));
            alloc.free_mask[i]  = (ent_state[i] == EMPTY);
            resp.ready_mask[i]  = (ent_state[i] == RESP_READY) && (ent_ord[i] == '0);
        end
    end

    // Same-ID writes still held, the one retiring now excluded
    always_comb begin
        alloc_ord = '0;
        for (int i = 0; i < `OST_DEPTH; i++) begin
            if ((ent_state[i] != EMPTY) && (ent_id[i] == alloc.alloc_id) &&
                !retire_hit[i]) begin
                alloc_ord = alloc_ord + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // Entry state and order count
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OST_DEPTH; i++) begin
                ent_state[i] <= EMPTY;
                ent_ord[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < `OST_DEPTH; i++) begin
                if (alloc_hit[i]) begin
                    ent_ord[i] <= alloc_ord;
                end else if (resp.retire && (ent_state[i] != EMPTY) &&
                             (ent_id[i] == resp.sel_id) && (ent_ord[i] != '0)) begin
                    ent_ord[i] <= ent_ord[i] - 1'b1;
                end

                case (ent_state[i])
                    EMPTY: begin
                        if (alloc_hit[i]) begin
                            ent_state[i] <= AWAIT_DATA;
                        end
                    end
                    AWAIT_DATA: begin
                        if (done_hit[i]) begin
                            ent_state[i] <= WAIT_BACKEND;
                        end
                    end
                    WAIT_BACKEND: begin
                        if (dly_hit[i]) begin
                            ent_state[i] <= RESP_READY;
                        end
                    end
                    RESP_READY: begin
                        if (retire_hit[i]) begin
                            ent_state[i] <= EMPTY;
                        end
                    end
                    default: ent_state[i] <= EMPTY;
                endcase
            end
        end
    end

    // ------------------------------------------------
    // Payload and backend delay counter
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < `OST_DEPTH; i++) begin
            if (alloc_hit[i]) begin
                ent_id[i]   <= alloc.alloc_id;
                ent_user[i] <= alloc.alloc_user;
                ent_resp[i] <= (alloc.alloc_id == id_t'(`ERR_ID)) ? SLVERR : OKAY;
            end
            if (done_hit[i]) begin
                ent_dly[i] <= DLY_W'(1);
            end else if ((ent_state[i] == WAIT_BACKEND) && !dly_hit[i]) begin
                ent_dly[i] <= ent_dly[i] + 1'b1;
            end
        end
    end

    // Fields of the slot the scheduler points at
    assign resp.sel_id   = ent_id[resp.sel_slot];
    assign resp.sel_user = ent_user[resp.sel_slot];
    assign resp.sel_resp = ent_resp[resp.sel_slot];

endmodule

// File: source/resp_sched.sv
// ------------------------------------------------
// Round-robin B channel scheduler
// Grant is held while bvalid waits for bready
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module resp_sched (
    input  logic               clk,
    input  logic               rst_n,
    output logic               bvalid,
    input  logic               bready,
    output axi_wr_pkg::id_t    bid,
    output axi_wr_pkg::bresp_e bresp,
    output axi_wr_pkg::user_t  buser,
    resp_if.sched              resp
);
    import axi_wr_pkg::*;

    slot_t last_r;
    slot_t hold_slot_r;
    logic  hold_r;
    slot_t rr_pick;
    slot_t grant;

    // Search starts one past the last granted slot
    always_comb begin
        slot_t idx;
        rr_pick = last_r;
        for (int k = `OST_DEPTH; k >= 1; k--) begin
            idx = last_r + slot_t'(k);
            if (resp.ready_mask[idx]) begin
                rr_pick = idx;
            end
        end
    end

    assign grant       = hold_r ? hold_slot_r : rr_pick;
    assign bvalid      = resp.ready_mask[grant];
    assign resp.sel_slot = grant;
    assign resp.retire = bvalid & bready;

    assign bid   = resp.sel_id;
    assign bresp = resp.sel_resp;
    assign buser = resp.sel_user;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_r      <= '0;
            hold_r      <= 1'b0;
            hold_slot_r <= '0;
        end else begin
            hold_r      <= bvalid & ~bready;
            hold_slot_r <= grant;
            if (resp.retire) begin
                last_r <= grant;
            end
        end
    end

endmodule

// File: source/axi_wr_slave.sv
// ------------------------------------------------
// AXI write slave, AW/W/B only
// Up to OST_DEPTH writes in flight, bursts to 8 beats
// ID 15 answers SLVERR, buser echoes awuser
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module axi_wr_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    // AW channel
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_ID_W-1:0]   awid,
    input  logic [`AXI_USER_W-1:0] awuser,
    input  logic [`AXI_LEN_W-1:0]  awlen,
    // W channel
    input  logic                   wvalid,
    output logic                   wready,
    input  logic                   wlast,
    // B channel
    output logic                   bvalid,
    input  logic                   bready,
    output logic [`AXI_ID_W-1:0]   bid,
    output logic [1:0]             bresp,
    output logic [`AXI_USER_W-1:0] buser
);

    alloc_if u_alloc_if ();
    resp_if  u_resp_if ();

    wr_intake u_intake (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awuser  (awuser),
        .awlen   (awlen),
        .wvalid  (wvalid),
        .wready  (wready),
        .wlast   (wlast),
        .alloc   (u_alloc_if.intake)
    );

    ost_table u_table (
        .clk   (clk),
        .rst_n (rst_n),
        .alloc (u_alloc_if.tbl),
        .resp  (u_resp_if.tbl)
    );

    resp_sched u_sched (
        .clk    (clk),
        .rst_n  (rst_n),
        .bvalid (bvalid),
        .bready (bready),
        .bid    (bid),
        .bresp  (bresp),
        .buser  (buser),
        .resp   (u_resp_if.sched)
    );

endmodule

// File: verif/axi_wr_slave_props.sv
// ------------------------------------------------
// Protocol assertions for the AXI write slave
// Bound into axi_wr_slave, counts failures in fail_cnt
// Write count follows AW and B handshakes only
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module axi_wr_slave_props (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   awvalid,
    input  logic                   awready,
    input  logic                   wready,
    input  logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ID_W-1:0]   bid,
    input  logic [1:0]             bresp,
    input  logic [`AXI_USER_W-1:0] buser
);
    import axi_wr_pkg::*;

    int                          fail_cnt = 0;
    logic [$clog2(`OST_DEPTH):0] in_flight;

    // Writes accepted on AW and not yet answered on B
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            case ({awvalid && awready, bvalid && bready})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // --------------------------------------------------
    // Reset values and B channel rules
    // --------------------------------------------------
    reset_idle: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (awready && !bvalid && !wready))
        else begin
            $error("outputs not idle around reset");
            fail_cnt++;
        end

    resp_code: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> (bresp == ((bid == `ERR_ID) ? SLVERR : OKAY)))
        else begin
            $error("bresp does not match bid");
            fail_cnt++;
        end

    b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=>
            (bvalid && $stable(bid) && $stable(bresp) && $stable(buser)))
        else begin
            $error("B channel changed while stalled");
            fail_cnt++;
        end

    // awready drops exactly when the table is full
    full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        awready == (in_flight != `OST_DEPTH))
        else begin
            $error("awready does not follow table occupancy");
            fail_cnt++;
        end

endmodule

// File: verif/tb_axi_wr_slave.sv
// ------------------------------------------------
// Testbench for the AXI write slave
// Inputs change on the falling edge, outputs read there
// DUT outputs depend on state only, so handshakes are
// known at the falling edge before the clock edge
// ------------------------------------------------
`timescale 1ns/1ns
`include "axi_wr_defs.svh"

module tb_axi_wr_slave;
    import axi_wr_pkg::*;

    localparam int NUM_TXN   = 200;
    localparam int CYC_LIMIT = NUM_TXN * 60;
    localparam int LEN_W     = `AXI_LEN_W;

    typedef struct packed {
        id_t         id;
        user_t       user;
        logic [3:0]  beats;
        logic        done;
        logic [31:0] done_cyc;
    } wr_rec_t;

    logic             clk;
    logic             rst_n;
    logic             awvalid;
    logic             awready;
    id_t              awid;
    user_t            awuser;
    logic [LEN_W-1:0] awlen;
    logic             wvalid;
    logic             wready;
    logic             wlast;
    logic             bvalid;
    logic             bready;
    id_t              bid;
    logic [1:0]       bresp;
    user_t            buser;

    logic [15:0] lfsr;
    int          cyc = 0;
    int          err_cnt;
    int          issued;
    int          gap;
    int          beats_sent;
    logic        aw_hs_next;
    logic        b_seen;
    user_t       seq [16];
    // Outstanding writes in AW order
    wr_rec_t     pend [$];

    axi_wr_slave UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awuser  (awuser),
        .awlen   (awlen),
        .wvalid  (wvalid),
        .wready  (wready),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .bresp   (bresp),
        .buser   (buser)
    );

    bind axi_wr_slave axi_wr_slave_props u_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .bresp   (bresp),
        .buser   (buser)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic int unsigned rand_bits(input int n);
        int unsigned val;
        logic        fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = (val << 1) | 32'(fb);
        end
        return val;
    endfunction

    // Oldest outstanding write with this ID, -1 if none
    function automatic int find_oldest(input id_t id);
        int idx;
        idx = -1;
        for (int i = pend.size() - 1; i >= 0; i--) begin
            if (pend[i].id == id) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic print_counts();
        $display("Errors: scoreboard %0d, assertions %0d", err_cnt, UUT.u_props.fail_cnt);
    endtask

    // --------------------------------------------------
    // Channel drivers and scoreboard
    // --------------------------------------------------
    task automatic drive_b();
        int idx;
        int lat;
        int min_lat;
        bready = (rand_bits(2) != 0);
        if (bvalid) begin
            idx = find_oldest(bid);
            known_id: assert (idx >= 0) else begin
                $display("B response with ID %0d has no outstanding write", bid);
                err_cnt++;
            end
            // Earliest handshake edge is one past 31 minus ID
            if (idx >= 0 && !b_seen) begin
                min_lat = `RESP_DLY_MAX - int'(bid) + 1;
                lat     = cyc - int'(pend[idx].done_cyc);
                resp_latency: assert (pend[idx].done && lat >= min_lat) else begin
                    $display("ERR resp_latency id=%0d expected >= %0d actual %0d",
                             bid, min_lat, lat);
                    err_cnt++;
                end
                b_seen = 1'b1;
            end
            if (idx >= 0 && bready) begin
                same_id_order: assert (buser == pend[idx].user) else begin
                    $display("ERR same_id_order id=%0d expected %0d actual %0d",
                             bid, pend[idx].user, buser);
                    err_cnt++;
                end
                pend.delete(idx);
            end
            if (bready) begin
                b_seen = 1'b0;
            end
        end
    endtask

    task automatic drive_w();
        int      head;
        wr_rec_t rec;
        head   = -1;
        wvalid = 1'b0;
        wlast  = 1'b0;
        for (int i = pend.size() - 1; i >= 0; i--) begin
            if (!pend[i].done) begin
                head = i;
            end
        end
        if (head >= 0 && rand_bits(2) != 0) begin
            wvalid = 1'b1;
            wlast  = ((beats_sent + 1) == int'(pend[head].beats));
        end
        if (wvalid && wready) begin
            if (wlast) begin
                rec          = pend[head];
                rec.done     = 1'b1;
                rec.done_cyc = 32'(cyc);
                pend[head]   = rec;
                beats_sent   = 0;
            end else begin
                beats_sent++;
            end
        end
    endtask

    task automatic drive_aw();
        wr_rec_t rec;
        if (aw_hs_next) begin
            awvalid = 1'b0;
        end
        if (!awvalid && issued < NUM_TXN) begin
            if (gap > 0) begin
                gap--;
            end else begin
                awid       = id_t'(rand_bits(4));
                awlen      = LEN_W'(rand_bits(3));
                awuser     = seq[awid];
                seq[awid]  = seq[awid] + 1'b1;
                awvalid    = 1'b1;
            end
        end
        aw_hs_next = awvalid && awready;
        if (aw_hs_next) begin
            rec.id       = awid;
            rec.user     = awuser;
            rec.beats    = 4'(awlen) + 4'd1;
            rec.done     = 1'b0;
            rec.done_cyc = '0;
            pend.push_back(rec);
            issued++;
            gap = int'(rand_bits(2));
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
            print_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_n      = 1'b0;
        awvalid    = 1'b0;
        awid       = '0;
        awuser     = '0;
        awlen      = '0;
        wvalid     = 1'b0;
        wlast      = 1'b0;
        bready     = 1'b0;
        lfsr       = 16'd26;
        err_cnt    = 0;
        issued     = 0;
        gap        = 0;
        beats_sent = 0;
        aw_hs_next = 1'b0;
        b_seen     = 1'b0;
        for (int i = 0; i < 16; i++) begin
            seq[i] = '0;
        end

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        while (issued < NUM_TXN || pend.size() != 0) begin
            @(negedge clk);
            drive_b();
            drive_w();
            drive_aw();
        end

        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wlast   = 1'b0;
        bready  = 1'b1;
        repeat (4) @(negedge clk);
        final_idle: assert (!bvalid && awready && !wready) else begin
            $display("DUT not idle after all responses returned");
            err_cnt++;
        end

        print_counts();
        if (err_cnt == 0 && UUT.u_props.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+source
source/axi_wr_pkg.sv
source/wr_slot_if.sv
source/wr_intake.sv
source/ost_table.sv
source/resp_sched.sv
source/axi_wr_slave.sv
verif/axi_wr_slave_props.sv
verif/tb_axi_wr_slave.sv

// File: Makefile
# Verilator build and run for the AXI write slave testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_wr_slave
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
